// File: hdl/adc_merge.sv
`timescale 1ns/1ps
`default_nettype none

`include "lidar_consts.svh"

module adc_merge (
    input  wire logic                      clk200,
    input  wire logic                      arst_n,
    input  wire logic                      adc_en,
    input  wire lidar_pkg::sample_t        adc_data,
    input  wire logic                      adc_of,
    output lidar_pkg::merge_t              merge_word,
    output logic                           merge_of,
    output logic                           merge_valid,
    output logic [`LIDAR_PHASE_W-1:0]      sample_phase
);

    lidar_pkg::merge_t acc;
    lidar_pkg::merge_t acc_next;
    logic              of_acc;
    logic              last;

    assign last = (sample_phase == `LIDAR_PHASE_W'(`LIDAR_MERGE_N - 1));

    // Current sample dropped into its slot
    always_comb begin
        acc_next = acc;
        acc_next[sample_phase*`LIDAR_SAMPLE_W +: `LIDAR_SAMPLE_W] = adc_data;
    end

    always_ff @(posedge clk200 or negedge arst_n) begin
        if (!arst_n) begin
            sample_phase <= '0;
            of_acc       <= 1'b0;
            merge_of     <= 1'b0;
            merge_valid  <= 1'b0;
        end else begin
            merge_valid <= adc_en && last;
            if (!adc_en) begin
                sample_phase <= '0;
                of_acc       <= 1'b0;
            end else if (last) begin
                sample_phase <= '0;
                merge_of     <= of_acc | adc_of;
                of_acc       <= 1'b0;
            end else begin
                sample_phase <= sample_phase + 1'b1;
                of_acc       <= of_acc | adc_of;
            end
        end
    end

    // Sample payload
    always_ff @(posedge clk200) begin
        if (adc_en) begin
            acc <= acc_next;
            if (last) begin
                merge_word <= acc_next;
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/capture_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "lidar_consts.svh"

module capture_ctrl #(
    parameter  int CAP_DEPTH = `LIDAR_CAP_DEPTH,
    localparam int IDX_W     = $clog2(CAP_DEPTH)
) (
    input  wire logic                      clk200,
    input  wire logic                      arst_n,
    input  wire logic                      cap_trig,
    input  wire logic [`LIDAR_PHASE_W-1:0] sample_phase,
    input  wire lidar_pkg::merge_t         merge_word,
    input  wire logic                      merge_of,
    input  wire logic                      merge_valid,
    input  wire logic                      cmpt_clr,
    input  wire logic [IDX_W-1:0]          buf_index,
    output lidar_pkg::cap_word_t           buf_rdata,
    output logic                           cap_cmpt,
    output logic [`LIDAR_PHASE_W-1:0]      cap_phase
);

    typedef enum logic [1:0] {
        st_idle,
        st_skip,
        st_store
    } state_t;

    state_t               state;
    logic [IDX_W-1:0]     word_cnt;
    logic                 armed;
    lidar_pkg::cap_word_t mem [CAP_DEPTH];

    assign armed     = (state == st_idle) && !cap_cmpt;
    assign buf_rdata = mem[buf_index];

    ////////////////////////////////////////
    // Capture FSM
    ////////////////////////////////////////

    always_ff @(posedge clk200 or negedge arst_n) begin
        if (!arst_n) begin
            state     <= st_idle;
            word_cnt  <= '0;
            cap_cmpt  <= 1'b0;
            cap_phase <= '0;
        end else begin
            if (cmpt_clr) begin
                cap_cmpt <= 1'b0;
            end
            case (state)
                st_idle: begin
                    if (cap_trig && armed) begin
                        // Trigger sample went in one edge earlier
                        cap_phase <= sample_phase - 1'b1;
                        word_cnt  <= '0;
                        // Its word may have completed on that same edge
                        state     <= merge_valid ? st_store : st_skip;
                    end
                end
                st_skip: begin
                    if (merge_valid) begin
                        state <= st_store;
                    end
                end
                st_store: begin
                    if (merge_valid) begin
                        word_cnt <= word_cnt + 1'b1;
                        if (word_cnt == IDX_W'(CAP_DEPTH - 1)) begin
                            cap_cmpt <= 1'b1;
                            state    <= st_idle;
                        end
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Buffer storage
    always_ff @(posedge clk200) begin
        if ((state == st_store) && merge_valid) begin
            mem[word_cnt] <= '{ovf: merge_of, data: merge_word};
        end
    end

endmodule

`default_nettype wire

// File: hdl/laser_pulse_gen.sv
`timescale 1ns/1ps
`default_nettype none

module laser_pulse_gen (
    input  wire logic              clk200,
    input  wire logic              arst_n,
    input  wire logic              ldd_en,
    input  wire logic              cmd_mode,
    input  wire logic [31:0]       period,
    input  wire lidar_pkg::wdis_t  wdis,
    input  wire logic              fire,
    output logic                   laser_pulse,
    output logic                   cap_trig
);

    logic [31:0]      period_eff;
    logic [31:0]      period_cnt;
    lidar_pkg::wdis_t width_cnt;
    logic             periodic;
    logic             start;

    // Shortest usable period is two clocks
    assign period_eff = (period < 32'd2) ? 32'd2 : period;
    assign periodic   = ldd_en && !cmd_mode;

    // No new pulse while one is still high
    assign start = ldd_en && !laser_pulse &&
                   (cmd_mode ? fire : (period_cnt == 32'd0));

    ////////////////////////////////////////
    // Period counter
    ////////////////////////////////////////

    always_ff @(posedge clk200 or negedge arst_n) begin
        if (!arst_n) begin
            period_cnt <= '0;
        end else if (!periodic) begin
            period_cnt <= '0;
        end else if (period_cnt >= period_eff - 32'd1) begin
            period_cnt <= '0;
        end else begin
            period_cnt <= period_cnt + 32'd1;
        end
    end

    ////////////////////////////////////////
    // Pulse shaping
    ////////////////////////////////////////

    always_ff @(posedge clk200 or negedge arst_n) begin
        if (!arst_n) begin
            laser_pulse <= 1'b0;
            width_cnt   <= '0;
            cap_trig    <= 1'b0;
        end else begin
            cap_trig <= start;
            if (start) begin
                laser_pulse <= 1'b1;
                width_cnt   <= wdis;
            end else if (laser_pulse) begin
                if (width_cnt == '0) begin
                    laser_pulse <= 1'b0;
                end else begin
                    width_cnt <= width_cnt - 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/lidar_pkg.sv
`default_nettype none

`include "lidar_consts.svh"

package lidar_pkg;

    // One ADC conversion
    typedef logic [`LIDAR_SAMPLE_W-1:0] sample_t;

    // Sample 0 sits in the low bits
    typedef logic [`LIDAR_MERGE_N*`LIDAR_SAMPLE_W-1:0] merge_t;

    typedef logic [`LIDAR_WDIS_W-1:0] wdis_t;

    // Overflow flag above the merged samples
    typedef struct packed {
        logic   ovf;
        merge_t data;
    } cap_word_t;

endpackage

`default_nettype wire

// File: hdl/lidar_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "lidar_consts.svh"

module lidar_regs (
    input  wire logic                      clk200,
    input  wire logic                      arst_n,
    input  wire logic                      psel,
    input  wire logic                      penable,
    input  wire logic                      pwrite,
    input  wire logic [`LIDAR_APB_AW-1:0]  paddr,
    input  wire logic [31:0]               pwdata,
    output logic [31:0]                    prdata,
    output logic                           pready,
    output logic                           pslverr,
    output logic                           ldd_en,
    output logic                           cmd_mode,
    output logic                           adc_en,
    output logic [31:0]                    period,
    output lidar_pkg::wdis_t               wdis,
    output logic                           fire,
    output logic                           cmpt_clr,
    output logic [3:0]                     buf_index,
    input  wire lidar_pkg::cap_word_t      buf_rdata,
    input  wire logic                      cap_cmpt,
    input  wire logic [`LIDAR_PHASE_W-1:0] cap_phase
);

    logic                     access;
    logic                     wr_en;
    logic                     in_buf;
    logic                     hit_reg;
    logic [`LIDAR_APB_AW-1:0] buf_off;
    logic [31:0]              buf_half;
    logic [31:0]              reg_rdata;

    assign access = psel && penable;
    assign wr_en  = access && pwrite;
    assign pready = 1'b1;

    ////////////////////////////////////////
    // Capture buffer window
    ////////////////////////////////////////

    assign in_buf = (32'(paddr) >= `LIDAR_BUF_BASE) &&
                    (32'(paddr) < `LIDAR_BUF_BASE + 8 * `LIDAR_CAP_DEPTH);

    assign buf_off   = paddr - `LIDAR_APB_AW'(`LIDAR_BUF_BASE);
    assign buf_index = buf_off[6:3];

    // High half carries the overflow flag in bit 24
    assign buf_half = paddr[2] ? 32'(buf_rdata[$bits(lidar_pkg::cap_word_t)-1:32])
                               : buf_rdata[31:0];

    ////////////////////////////////////////
    // Register read decode
    ////////////////////////////////////////

    always_comb begin
        hit_reg   = 1'b1;
        reg_rdata = '0;
        case (paddr)
            `LIDAR_REG_CTRL: begin
                reg_rdata[0] = ldd_en;
                reg_rdata[1] = adc_en;
                reg_rdata[2] = cmd_mode;
            end
            `LIDAR_REG_PERIOD: reg_rdata = period;
            `LIDAR_REG_WDIS:   reg_rdata = 32'(wdis);
            `LIDAR_REG_FIRE:   reg_rdata = '0;
            `LIDAR_REG_STATUS: begin
                reg_rdata[0]                  = cap_cmpt;
                reg_rdata[4+:`LIDAR_PHASE_W] = cap_phase;
            end
            default: hit_reg = 1'b0;
        endcase
    end

    assign prdata = in_buf ? buf_half : reg_rdata;

    // Buffer window is read only
    assign pslverr = access && (in_buf ? pwrite : !hit_reg);

    ////////////////////////////////////////
    // Configuration and strobes
    ////////////////////////////////////////

    always_ff @(posedge clk200 or negedge arst_n) begin
        if (!arst_n) begin
            ldd_en   <= 1'b0;
            adc_en   <= 1'b0;
            cmd_mode <= 1'b0;
            period   <= '0;
            wdis     <= '0;
            fire     <= 1'b0;
            cmpt_clr <= 1'b0;
        end else begin
            fire     <= wr_en && (paddr == `LIDAR_REG_FIRE) && pwdata[0];
            cmpt_clr <= wr_en && (paddr == `LIDAR_REG_STATUS) && pwdata[0];
            if (wr_en) begin
                case (paddr)
                    `LIDAR_REG_CTRL: begin
                        ldd_en   <= pwdata[0];
                        adc_en   <= pwdata[1];
                        cmd_mode <= pwdata[2];
                    end
                    `LIDAR_REG_PERIOD: period <= pwdata;
                    `LIDAR_REG_WDIS:   wdis <= pwdata[`LIDAR_WDIS_W-1:0];
                    default: ;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/lidar_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "lidar_consts.svh"

module lidar_top (
    input  wire logic                     clk200,
    input  wire logic                     arst_n,
    input  wire logic                     psel,
    input  wire logic                     penable,
    input  wire logic                     pwrite,
    input  wire logic [`LIDAR_APB_AW-1:0] paddr,
    input  wire logic [31:0]              pwdata,
    output logic [31:0]                   prdata,
    output logic                          pready,
    output logic                          pslverr,
    input  wire lidar_pkg::sample_t       adc_data,
    input  wire logic                     adc_of,
    output logic                          laser_pulse,
    output logic                          cap_irq
);

    logic                      ldd_en;
    logic                      cmd_mode;
    logic                      adc_en;
    logic [31:0]               period;
    lidar_pkg::wdis_t          wdis;
    logic                      fire;
    logic                      cmpt_clr;
    logic [3:0]                buf_index;
    lidar_pkg::cap_word_t      buf_rdata;
    logic [`LIDAR_PHASE_W-1:0] cap_phase;
    logic                      cap_trig;
    lidar_pkg::merge_t         merge_word;
    logic                      merge_of;
    logic                      merge_valid;
    logic [`LIDAR_PHASE_W-1:0] sample_phase;

    lidar_regs lidar_regs_ins0 (
        .clk200    (clk200),
        .arst_n    (arst_n),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .ldd_en    (ldd_en),
        .cmd_mode  (cmd_mode),
        .adc_en    (adc_en),
        .period    (period),
        .wdis      (wdis),
        .fire      (fire),
        .cmpt_clr  (cmpt_clr),
        .buf_index (buf_index),
        .buf_rdata (buf_rdata),
        .cap_cmpt  (cap_irq),
        .cap_phase (cap_phase)
    );

    laser_pulse_gen laser_pulse_gen_ins0 (
        .clk200      (clk200),
        .arst_n      (arst_n),
        .ldd_en      (ldd_en),
        .cmd_mode    (cmd_mode),
        .period      (period),
        .wdis        (wdis),
        .fire        (fire),
        .laser_pulse (laser_pulse),
        .cap_trig    (cap_trig)
    );

    adc_merge adc_merge_ins0 (
        .clk200       (clk200),
        .arst_n       (arst_n),
        .adc_en       (adc_en),
        .adc_data     (adc_data),
        .adc_of       (adc_of),
        .merge_word   (merge_word),
        .merge_of     (merge_of),
        .merge_valid  (merge_valid),
        .sample_phase (sample_phase)
    );

    // Completion flag doubles as the interrupt line
    capture_ctrl #(
        .CAP_DEPTH (`LIDAR_CAP_DEPTH)
    ) capture_ctrl_ins0 (
        .clk200       (clk200),
        .arst_n       (arst_n),
        .cap_trig     (cap_trig),
        .sample_phase (sample_phase),
        .merge_word   (merge_word),
        .merge_of     (merge_of),
        .merge_valid  (merge_valid),
        .cmpt_clr     (cmpt_clr),
        .buf_index    (buf_index),
        .buf_rdata    (buf_rdata),
        .cap_cmpt     (cap_irq),
        .cap_phase    (cap_phase)
    );

endmodule

`default_nettype wire

// File: include/lidar_consts.svh
`ifndef LIDAR_CONSTS_SVH
`define LIDAR_CONSTS_SVH

////////////////////////////////////////
// ADC sample path
////////////////////////////////////////

`define LIDAR_SAMPLE_W   14
`define LIDAR_MERGE_N    4
`define LIDAR_PHASE_W    2

// Laser-driver pulse width code
`define LIDAR_WDIS_W     3

// Merged words kept per capture
`define LIDAR_CAP_DEPTH  16

////////////////////////////////////////
// APB register map
////////////////////////////////////////

`define LIDAR_APB_AW     8
`define LIDAR_REG_CTRL   'h00
`define LIDAR_REG_PERIOD 'h04
`define LIDAR_REG_WDIS   'h08
`define LIDAR_REG_FIRE   'h0C
`define LIDAR_REG_STATUS 'h10
// Two 32-bit halves per captured word
`define LIDAR_BUF_BASE   'h80

`endif

// File: project.f
+incdir+include
hdl/lidar_pkg.sv
hdl/lidar_regs.sv
hdl/laser_pulse_gen.sv
hdl/adc_merge.sv
hdl/capture_ctrl.sv
hdl/lidar_top.sv
sim/lidar_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the lidar testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --top-module lidar_tb -f project.f -o lidar_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/lidar_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^RESULT: PASS$" "$LOG"; then
    exit 0
fi
exit 1

// File: sim/lidar_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "lidar_consts.svh"

module lidar_tb;

    localparam int CLK_PERIOD  = 8;
    localparam int N_PULSES    = 5;
    localparam int IDLE_WIN    = 60;
    // Rough cycle budget of each test in run order
    localparam int TEST_CYCLES = 50 + 300 + 300 + 300 + 300 + 600;
    localparam int WATCHDOG_NS = TEST_CYCLES * CLK_PERIOD * 2;

    logic                     clk200;
    logic                     arst_n;
    logic                     psel;
    logic                     penable;
    logic                     pwrite;
    logic [`LIDAR_APB_AW-1:0] paddr;
    logic [31:0]              pwdata;
    logic [31:0]              prdata;
    logic                     pready;
    logic                     pslverr;
    lidar_pkg::sample_t       adc_data;
    logic                     adc_of;
    logic                     laser_pulse;
    logic                     cap_irq;

    logic [31:0] lfsr_state;
    logic        ramp_run;
    int          ramp_val;
    logic [13:0] of_pos [3];
    int          of_cnt;
    int          cycle;
    logic [13:0] adc_at_edge;
    logic [13:0] trig_sample;
    logic        pulse_q;
    int          high_cnt;
    int          rise_q [$];
    int          width_q [$];
    int          checks;
    int          errors;
    int          err_mark;
    int          tests_run;
    int          tests_failed;

    lidar_top dut (
        .clk200      (clk200),
        .arst_n      (arst_n),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .adc_data    (adc_data),
        .adc_of      (adc_of),
        .laser_pulse (laser_pulse),
        .cap_irq     (cap_irq)
    );

    initial begin
        clk200 = 1'b0;
        forever #(CLK_PERIOD / 2) clk200 = ~clk200;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("TIMEOUT: run did not finish within %0d ns", WATCHDOG_NS);
        $display("RESULT: FAIL");
        $finish;
    end

    ////////////////////////////////////////
    // ADC ramp and pulse monitor
    ////////////////////////////////////////

    always @(negedge clk200) begin
        if (ramp_run) begin
            adc_data = 14'(ramp_val);
            adc_of   = 1'b0;
            for (int j = 0; j < of_cnt; j++) begin
                if (of_pos[j] == 14'(ramp_val)) begin
                    adc_of = 1'b1;
                end
            end
            ramp_val++;
        end else begin
            ramp_val = 0;
            adc_of   = 1'b0;
        end
    end

    always @(posedge clk200) begin
        cycle       <= cycle + 1;
        adc_at_edge <= adc_data;
    end

    // Rise cycle, trigger sample and high time of each laser pulse
    always @(negedge clk200) begin
        if (laser_pulse && !pulse_q) begin
            rise_q.push_back(cycle);
            trig_sample = adc_at_edge;
            high_cnt    = 0;
        end
        if (laser_pulse) begin
            high_cnt++;
        end else if (pulse_q) begin
            width_q.push_back(high_cnt);
        end
        pulse_q = laser_pulse;
    end

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////

    function automatic logic lfsr_next();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_next()};
        end
        return v;
    endfunction

    // Word k starts four samples past the word holding the trigger sample
    function automatic logic [56:0] ref_word(input logic [13:0] t, input int k);
        logic [56:0] w;
        int          first;
        w     = '0;
        first = int'(t) - int'(t) % 4 + 4 * (k + 1);
        for (int i = 0; i < `LIDAR_MERGE_N; i++) begin
            w[i*`LIDAR_SAMPLE_W +: `LIDAR_SAMPLE_W] = 14'(first + i);
            for (int j = 0; j < of_cnt; j++) begin
                if (of_pos[j] == 14'(first + i)) begin
                    w[56] = 1'b1;
                end
            end
        end
        return w;
    endfunction

    task automatic check_val(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            $display("ERROR at %0t ns: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic apb_xfer(input logic wr, input logic [`LIDAR_APB_AW-1:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
        @(negedge clk200);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk200);
        penable = 1'b1;
        #(CLK_PERIOD / 2 - 1);
        rdata = prdata;
        err   = pslverr;
        check_val("pready", 64'(pready), 64'd1);
        @(posedge clk200);
        if (wr && (addr == 8'(`LIDAR_REG_CTRL))) begin
            ramp_run = wdata[1];
        end
        @(negedge clk200);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic write_reg(input logic [`LIDAR_APB_AW-1:0] addr, input logic [31:0] data);
        logic [31:0] rd;
        logic        err;
        apb_xfer(1'b1, addr, data, rd, err);
        check_val($sformatf("pslverr wr 0x%02h", addr), 64'(err), 64'd0);
    endtask

    task automatic read_reg(input logic [`LIDAR_APB_AW-1:0] addr, output logic [31:0] data);
        logic err;
        apb_xfer(1'b0, addr, 32'd0, data, err);
        check_val($sformatf("pslverr rd 0x%02h", addr), 64'(err), 64'd0);
    endtask

    task automatic wait_pulses(input int n, input logic rise_only, input int max_cycles);
        int cnt;
        cnt = 0;
        while (((rise_only ? rise_q.size() : width_q.size()) < n) && (cnt < max_cycles)) begin
            @(negedge clk200);
            cnt++;
        end
        if ((rise_only ? rise_q.size() : width_q.size()) < n) begin
            $display("TIMEOUT: fewer than %0d laser pulses within %0d cycles", n, max_cycles);
            errors++;
        end
    endtask

    task automatic wait_irq(input int max_cycles);
        int cnt;
        cnt = 0;
        while (!cap_irq && (cnt < max_cycles)) begin
            @(negedge clk200);
            cnt++;
        end
        if (!cap_irq) begin
            $display("TIMEOUT: cap_irq did not rise within %0d cycles", max_cycles);
            errors++;
        end
    endtask

    task automatic verify_capture(input logic [13:0] t);
        logic [31:0] rd;
        logic [56:0] exp;
        read_reg(8'(`LIDAR_REG_STATUS), rd);
        check_val("status.cap_cmpt", 64'(rd[0]), 64'd1);
        check_val("status.cap_phase", 64'(rd[5:4]), 64'(int'(t) % 4));
        for (int k = 0; k < `LIDAR_CAP_DEPTH; k++) begin
            exp = ref_word(t, k);
            read_reg(8'(`LIDAR_BUF_BASE + 8 * k), rd);
            check_val($sformatf("buf[%0d].lo", k), 64'(rd), 64'(exp[31:0]));
            read_reg(8'(`LIDAR_BUF_BASE + 8 * k + 4), rd);
            check_val($sformatf("buf[%0d].hi", k), 64'(rd), 64'(exp[56:32]));
        end
    endtask

    // Re-arm, fire once and check the new capture
    task automatic run_capture(input int n_of, output logic [13:0] t);
        write_reg(8'(`LIDAR_REG_STATUS), 32'd1);
        @(negedge clk200);
        check_val("cap_irq", 64'(cap_irq), 64'd0);
        of_cnt = 0;
        rise_q.delete();
        write_reg(8'(`LIDAR_REG_FIRE), 32'd1);
        wait_pulses(1, 1'b1, 20);
        t = trig_sample;
        for (int i = 0; i < n_of; i++) begin
            of_pos[i] = 14'(int'(t) - int'(t) % 4 + 12 + int'(rand_bits(6) % 56));
        end
        of_cnt = n_of;
        wait_irq(200);
        verify_capture(t);
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors != err_mark) begin
            tests_failed++;
        end
        $display("test %-14s %s", name, (errors == err_mark) ? "passed" : "failed");
        err_mark = errors;
    endtask

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////

    initial begin
        logic [31:0] rd;
        logic        err;
        logic [13:0] t;
        logic [13:0] t_prev;
        logic [2:0]  wd;
        int          per;
        arst_n     = 1'b0;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        adc_data   = '0;
        adc_of     = 1'b0;
        lfsr_state = 32'h0a69_256f;
        ramp_run   = 1'b0;
        ramp_val   = 0;
        of_cnt     = 0;
        cycle      = 0;
        pulse_q    = 1'b0;
        high_cnt   = 0;
        checks     = 0;
        errors     = 0;
        err_mark   = 0;
        tests_run  = 0;
        tests_failed = 0;
        repeat (2) @(posedge clk200);
        @(negedge clk200);
        arst_n = 1'b1;

        check_val("laser_pulse", 64'(laser_pulse), 64'd0);
        check_val("cap_irq", 64'(cap_irq), 64'd0);
        for (int a = 0; a <= 'h10; a += 4) begin
            read_reg(8'(a), rd);
            check_val($sformatf("reg 0x%02h", a), 64'(rd), 64'd0);
        end
        apb_xfer(1'b0, 8'h14, 32'd0, rd, err);
        check_val("pslverr rd 0x14", 64'(err), 64'd1);
        apb_xfer(1'b0, 8'h7C, 32'd0, rd, err);
        check_val("pslverr rd 0x7c", 64'(err), 64'd1);
        apb_xfer(1'b1, 8'(`LIDAR_BUF_BASE), 32'hFFFF_FFFF, rd, err);
        check_val("pslverr wr buf", 64'(err), 64'd1);
        end_test("reset_errors");

        wd  = 3'(rand_bits(3));
        per = 4 + int'(rand_bits(6) % 37);
        // Keep the pulse shorter than the period
        if (per < int'(wd) + 2) begin
            per = int'(wd) + 2;
        end
        write_reg(8'(`LIDAR_REG_PERIOD), 32'(per));
        write_reg(8'(`LIDAR_REG_WDIS), 32'(wd));
        rise_q.delete();
        width_q.delete();
        write_reg(8'(`LIDAR_REG_CTRL), 32'h3);
        wait_pulses(N_PULSES, 1'b0, N_PULSES * 45 + 20);
        for (int i = 1; i < rise_q.size(); i++) begin
            check_val("pulse spacing", 64'(rise_q[i] - rise_q[i-1]), 64'(per));
        end
        foreach (width_q[i]) begin
            check_val("pulse width", 64'(width_q[i]), 64'(int'(wd) + 1));
        end
        end_test("periodic");

        write_reg(8'(`LIDAR_REG_CTRL), 32'h7);
        // Let the capture from the first periodic trigger land
        wait_irq(200);
        @(negedge clk200);
        rise_q.delete();
        width_q.delete();
        repeat (IDLE_WIN) @(negedge clk200);
        check_val("pulses without fire", 64'(rise_q.size()), 64'd0);
        // Drop the width of a periodic pulse still high at the mode switch
        width_q.delete();
        write_reg(8'(`LIDAR_REG_FIRE), 32'd1);
        wait_pulses(1, 1'b0, 30);
        check_val("fired pulse width", 64'(width_q[0]), 64'(int'(wd) + 1));
        write_reg(8'(`LIDAR_REG_WDIS), 32'd7);
        rise_q.delete();
        width_q.delete();
        write_reg(8'(`LIDAR_REG_FIRE), 32'd1);
        write_reg(8'(`LIDAR_REG_FIRE), 32'd1);
        wait_pulses(1, 1'b0, 30);
        repeat (10) @(negedge clk200);
        check_val("pulses for two fires", 64'(rise_q.size()), 64'd1);
        check_val("long pulse width", 64'(width_q[0]), 64'd8);
        end_test("command");

        run_capture(0, t);
        end_test("capture");

        run_capture(3, t);
        end_test("overflow");

        t_prev = t;
        rise_q.delete();
        width_q.delete();
        write_reg(8'(`LIDAR_REG_FIRE), 32'd1);
        wait_pulses(1, 1'b0, 30);
        repeat (80) @(negedge clk200);
        check_val("cap_irq held", 64'(cap_irq), 64'd1);
        verify_capture(t_prev);
        run_capture(0, t);
        end_test("backpressure");

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
